//--- common/cim_pkg.sv
// controller interface packet path definitions
// frame widths, position codes and the grouped signal types
package cim_pkg;

    // word layout
    localparam int WORD_W = 134;
    localparam int DATA_W = 128;
    localparam int PORT_W = 4;

    localparam logic [PORT_W-1:0] HOST_PORT = 4'd8;

    // position codes in bits 133:132
    localparam logic [1:0] POS_HEAD = 2'b01;
    localparam logic [1:0] POS_BODY = 2'b11;
    localparam logic [1:0] POS_TAIL = 2'b10;

    // frame type carried in the encapsulation header
    localparam logic [15:0] ENCAP_TAG = 16'h1662;

    // external buffer
    localparam int FIFO_DEPTH      = 512;
    localparam int FIFO_LVL_W      = 10;
    localparam int MAX_FRAME_WORDS = 9;

    localparam int CNT_W = 16;

    typedef struct packed {
        logic [1:0]                 pos;
        logic [WORD_W-DATA_W-3:0]   rsv;
        logic [DATA_W-1:0]          data;
    } frame_word_t;

    typedef struct packed {
        logic        wr;
        frame_word_t word;
    } frame_bus_t;

    typedef struct packed {
        logic [CNT_W-1:0] inpkt_cnt;
        logic [CNT_W-1:0] outpkt_cnt;
        logic [CNT_W-1:0] drop_cnt;
    } cim_stat_t;

endpackage

//--- logic/frame_dmux.sv
// frame demultiplexer
// sends host port frames to decapsulation and all others to encapsulation
`timescale 1ns/100ps

module frame_dmux (
    input  logic                         i_clk,
    input  logic                         i_rst_n,
    input  cim_pkg::frame_bus_t          i_frame,
    input  logic [cim_pkg::PORT_W-1:0]   i_inport,
    output cim_pkg::frame_bus_t          o_encap,
    output logic [cim_pkg::PORT_W-1:0]   o_encap_port,
    output cim_pkg::frame_bus_t          o_decap
);
    import cim_pkg::*;

    logic              w_head;
    logic              w_to_decap;
    logic              r_route_decap;
    logic              r_encap_wr;
    logic              r_decap_wr;
    logic [PORT_W-1:0] r_port;
    frame_word_t       r_word;

    assign w_head = i_frame.wr && (i_frame.word.pos == POS_HEAD);

    // route decided at the head and held for the body and tail
    assign w_to_decap = w_head ? (i_inport == HOST_PORT) : r_route_decap;

    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            r_route_decap <= 1'b0;
            r_encap_wr    <= 1'b0;
            r_decap_wr    <= 1'b0;
            r_port        <= '0;
        end else begin
            if (w_head) begin
                r_route_decap <= w_to_decap;
                r_port        <= i_inport;
            end
            r_encap_wr <= i_frame.wr && !w_to_decap;
            r_decap_wr <= i_frame.wr && w_to_decap;
        end
    end

    always_ff @(posedge i_clk) begin
        r_word <= i_frame.word;
    end

    // both paths see the same word but only one strobe is raised
    assign o_encap      = '{wr: r_encap_wr, word: r_word};
    assign o_decap      = '{wr: r_decap_wr, word: r_word};
    assign o_encap_port = r_port;

endmodule

//--- encap/frame_encap.sv
// frame encapsulation
// puts a header word with the frame type and input port in front of each frame
`timescale 1ns/100ps

module frame_encap (
    input  logic                         i_clk,
    input  logic                         i_rst_n,
    input  cim_pkg::frame_bus_t          i_frame,
    input  logic [cim_pkg::PORT_W-1:0]   i_inport,
    output cim_pkg::frame_bus_t          o_frame
);
    import cim_pkg::*;

    logic        w_head;
    frame_word_t w_hdr;
    logic        r_dly_wr;
    frame_word_t r_dly_word;
    logic        r_out_wr;
    frame_word_t r_out_word;

    assign w_head = i_frame.wr && (i_frame.word.pos == POS_HEAD);

    // header word with the tag on top and the port at the bottom
    always_comb begin
        w_hdr                      = '0;
        w_hdr.pos                  = POS_HEAD;
        w_hdr.data[DATA_W-1 -: 16] = ENCAP_TAG;
        w_hdr.data[PORT_W-1:0]     = i_inport;
    end

    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            r_dly_wr <= 1'b0;
            r_out_wr <= 1'b0;
        end else begin
            r_dly_wr <= i_frame.wr;
            r_out_wr <= w_head || r_dly_wr;
        end
    end

    //**************************************************************************
    // data path
    //**************************************************************************
    // idle gap before a head keeps the delay stage empty while the header
    // goes out so the two sources never collide
    always_ff @(posedge i_clk) begin
        r_dly_word <= i_frame.word;
        if (w_head) begin
            // old head becomes a body word behind the new header
            r_dly_word.pos <= POS_BODY;
        end
        r_out_word <= w_head ? w_hdr : r_dly_word;
    end

    assign o_frame = '{wr: r_out_wr, word: r_out_word};

endmodule

//--- decap/frame_decap.sv
// frame decapsulation
// strips the leading header word and marks the next word as the new head
`timescale 1ns/100ps

module frame_decap (
    input  logic                 i_clk,
    input  logic                 i_rst_n,
    input  cim_pkg::frame_bus_t  i_frame,
    output cim_pkg::frame_bus_t  o_frame
);
    import cim_pkg::*;

    logic        w_head;
    logic        r_first;
    logic        r_out_wr;
    frame_word_t r_out_word;

    assign w_head = i_frame.wr && (i_frame.word.pos == POS_HEAD);

    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            r_first  <= 1'b0;
            r_out_wr <= 1'b0;
        end else begin
            // set at the header and cleared by the first surviving word
            if (w_head) begin
                r_first <= 1'b1;
            end else if (i_frame.wr) begin
                r_first <= 1'b0;
            end
            r_out_wr <= i_frame.wr && !w_head;
        end
    end

    always_ff @(posedge i_clk) begin
        r_out_word <= i_frame.word;
        if (r_first) begin
            r_out_word.pos <= POS_HEAD;
        end
    end

    assign o_frame = '{wr: r_out_wr, word: r_out_word};

    // a stripped header must be followed by frame data, not another header
    a_no_double_head: assert property (@(posedge i_clk) disable iff (!i_rst_n)
        w_head |=> !w_head);

endmodule

//--- logic/frame_merge.sv
// frame merger
// joins the encapsulation and decapsulation paths into the external buffer,
// dropping whole frames when the buffer cannot take a full frame
`timescale 1ns/100ps

module frame_merge (
    input  logic                            i_clk,
    input  logic                            i_rst_n,
    input  cim_pkg::frame_bus_t             i_encap,
    input  cim_pkg::frame_bus_t             i_decap,
    input  logic [cim_pkg::FIFO_LVL_W-1:0]  i_fifo_level,
    output cim_pkg::frame_bus_t             o_frame,
    output logic                            o_drop_pulse
);
    import cim_pkg::*;

    frame_bus_t  w_in;
    logic        w_head;
    logic        w_tail;
    logic        w_over;
    logic        w_keep;
    logic        r_drop;
    logic        r_out_wr;
    logic        r_drop_pulse;
    frame_word_t r_out_word;

    // at most one path is active, so a masked OR picks it
    assign w_in = (i_encap & {$bits(frame_bus_t){i_encap.wr}})
                | (i_decap & {$bits(frame_bus_t){i_decap.wr}});

    assign w_head = w_in.wr && (w_in.word.pos == POS_HEAD);
    assign w_tail = w_in.wr && (w_in.word.pos == POS_TAIL);

    // room for the longest frame is needed at the head
    assign w_over = i_fifo_level > FIFO_LVL_W'(FIFO_DEPTH - MAX_FRAME_WORDS);
    assign w_keep = w_head ? !w_over : !r_drop;

    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            r_drop       <= 1'b0;
            r_out_wr     <= 1'b0;
            r_drop_pulse <= 1'b0;
        end else begin
            if (w_head) begin
                r_drop <= w_over;
            end else if (w_tail) begin
                r_drop <= 1'b0;
            end
            r_out_wr     <= w_in.wr && w_keep;
            r_drop_pulse <= w_head && w_over;
        end
    end

    always_ff @(posedge i_clk) begin
        r_out_word <= w_in.word;
    end

    assign o_frame      = '{wr: r_out_wr, word: r_out_word};
    assign o_drop_pulse = r_drop_pulse;

    // relies on the idle gap at the block input and the path latencies
    a_one_path: assert property (@(posedge i_clk) disable iff (!i_rst_n)
        !(i_encap.wr && i_decap.wr));

endmodule

//--- logic/sync_fifo.sv
// single clock FIFO for the external frame buffer
// show-ahead read data and a fill level for the merger
`timescale 1ns/100ps

module sync_fifo (
    input  logic                            i_clk,
    input  logic                            i_rst_n,
    input  logic                            i_wr,
    input  cim_pkg::frame_word_t            i_wr_word,
    input  logic                            i_rd,
    output cim_pkg::frame_word_t            o_rd_word,
    output logic                            o_empty,
    output logic [cim_pkg::FIFO_LVL_W-1:0]  o_level
);
    import cim_pkg::*;

    frame_word_t             mem [FIFO_DEPTH];
    logic [FIFO_LVL_W-2:0]   r_wr_ptr;
    logic [FIFO_LVL_W-2:0]   r_rd_ptr;
    logic [FIFO_LVL_W-1:0]   r_level;
    logic                    w_full;
    logic                    w_wr_en;
    logic                    w_rd_en;

    assign w_full  = (r_level == FIFO_LVL_W'(FIFO_DEPTH));
    assign o_empty = (r_level == '0);
    assign w_wr_en = i_wr && !w_full;
    assign w_rd_en = i_rd && !o_empty;

    always_ff @(posedge i_clk) begin
        if (w_wr_en) begin
            mem[r_wr_ptr] <= i_wr_word;
        end
    end

    // pointers wrap at the depth
    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            r_wr_ptr <= '0;
            r_rd_ptr <= '0;
            r_level  <= '0;
        end else begin
            if (w_wr_en) begin
                r_wr_ptr <= r_wr_ptr + 1'b1;
            end
            if (w_rd_en) begin
                r_rd_ptr <= r_rd_ptr + 1'b1;
            end
            case ({w_wr_en, w_rd_en})
                2'b10:   r_level <= r_level + 1'b1;
                2'b01:   r_level <= r_level - 1'b1;
                default: r_level <= r_level;
            endcase
        end
    end

    // head of queue visible while not empty
    assign o_rd_word = mem[r_rd_ptr];
    assign o_level   = r_level;

    a_no_overflow: assert property (@(posedge i_clk) disable iff (!i_rst_n)
        !(i_wr && w_full));
    a_no_underflow: assert property (@(posedge i_clk) disable iff (!i_rst_n)
        !(i_rd && o_empty));

endmodule

//--- logic/pkt_statistics.sv
// frame statistics
// counts frames entering the block, frames read out and dropped frames
`timescale 1ns/100ps

module pkt_statistics (
    input  logic                  i_clk,
    input  logic                  i_rst_n,
    input  cim_pkg::frame_bus_t   i_frame,
    input  logic                  i_fifo_rd,
    input  cim_pkg::frame_word_t  i_fifo_word,
    input  logic                  i_drop_pulse,
    output cim_pkg::cim_stat_t    o_stat
);
    import cim_pkg::*;

    cim_stat_t r_stat;
    logic      w_in_head;
    logic      w_out_head;

    assign w_in_head  = i_frame.wr && (i_frame.word.pos == POS_HEAD);
    assign w_out_head = i_fifo_rd && (i_fifo_word.pos == POS_HEAD);

    // all counters wrap
    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            r_stat <= '0;
        end else begin
            if (w_in_head) begin
                r_stat.inpkt_cnt <= r_stat.inpkt_cnt + 1'b1;
            end
            if (w_out_head) begin
                r_stat.outpkt_cnt <= r_stat.outpkt_cnt + 1'b1;
            end
            if (i_drop_pulse) begin
                r_stat.drop_cnt <= r_stat.drop_cnt + 1'b1;
            end
        end
    end

    assign o_stat = r_stat;

endmodule

//--- logic/cim_top.sv
// controller interface packet path, top level
// dmux, encap and decap paths, merger, external buffer and statistics
`timescale 1ns/100ps

module cim_top (
    input  logic                         i_clk,
    input  logic                         i_rst_n,
    input  cim_pkg::frame_bus_t          i_frame,
    input  logic [cim_pkg::PORT_W-1:0]   i_inport,
    output cim_pkg::frame_word_t         o_fifo_word,
    output logic                         o_fifo_empty,
    input  logic                         i_fifo_rd,
    output cim_pkg::cim_stat_t           o_stat
);
    import cim_pkg::*;

    // dmux to the two paths
    frame_bus_t              w_dmux2encap;
    frame_bus_t              w_dmux2decap;
    logic [PORT_W-1:0]       w_encap_port;
    // paths to merger
    frame_bus_t              w_encap2merge;
    frame_bus_t              w_decap2merge;
    // merger and buffer
    frame_bus_t              w_merge2fifo;
    logic [FIFO_LVL_W-1:0]   w_fifo_level;
    logic                    w_drop_pulse;

    frame_dmux frame_dmux_inst (
        .i_clk        (i_clk),
        .i_rst_n      (i_rst_n),
        .i_frame      (i_frame),
        .i_inport     (i_inport),
        .o_encap      (w_dmux2encap),
        .o_encap_port (w_encap_port),
        .o_decap      (w_dmux2decap)
    );

    frame_encap frame_encap_inst (
        .i_clk    (i_clk),
        .i_rst_n  (i_rst_n),
        .i_frame  (w_dmux2encap),
        .i_inport (w_encap_port),
        .o_frame  (w_encap2merge)
    );

    frame_decap frame_decap_inst (
        .i_clk   (i_clk),
        .i_rst_n (i_rst_n),
        .i_frame (w_dmux2decap),
        .o_frame (w_decap2merge)
    );

    frame_merge frame_merge_inst (
        .i_clk        (i_clk),
        .i_rst_n      (i_rst_n),
        .i_encap      (w_encap2merge),
        .i_decap      (w_decap2merge),
        .i_fifo_level (w_fifo_level),
        .o_frame      (w_merge2fifo),
        .o_drop_pulse (w_drop_pulse)
    );

    // external buffer
    sync_fifo cim_ext_buffer (
        .i_clk     (i_clk),
        .i_rst_n   (i_rst_n),
        .i_wr      (w_merge2fifo.wr),
        .i_wr_word (w_merge2fifo.word),
        .i_rd      (i_fifo_rd),
        .o_rd_word (o_fifo_word),
        .o_empty   (o_fifo_empty),
        .o_level   (w_fifo_level)
    );

    pkt_statistics pkt_statistics_inst (
        .i_clk        (i_clk),
        .i_rst_n      (i_rst_n),
        .i_frame      (i_frame),
        .i_fifo_rd    (i_fifo_rd),
        .i_fifo_word  (o_fifo_word),
        .i_drop_pulse (w_drop_pulse),
        .o_stat       (o_stat)
    );

endmodule

//--- bench/tb_clock.sv
// testbench clock source
// free running clock with an 8 ns period by default
`timescale 1ns/100ps

module tb_clock #(
    parameter real PERIOD_NS = 8.0
) (
    output logic o_clk
);

    initial begin
        o_clk = 1'b0;
    end

    always begin
        #(PERIOD_NS / 2.0);
        o_clk = ~o_clk;
    end

endmodule

//--- bench/cim_tb.sv
// testbench for the controller interface packet path
// random mixed frames checked against a queue model, then a buffer overrun test
`timescale 1ns/100ps

module cim_tb;
    import cim_pkg::*;

    localparam int N_CONT         = 200;
    localparam int N_BLOCK        = 150;
    localparam int TIMEOUT_CYCLES = (N_CONT + N_BLOCK) * 20 + 1000;

    logic              clk;
    logic              rst_n;
    frame_bus_t        in_frame;
    logic [PORT_W-1:0] in_port;
    frame_word_t       fifo_word;
    logic              fifo_empty;
    logic              fifo_rd;
    cim_stat_t         stat;

    logic [15:0] lfsr_state = 16'd55372;
    frame_word_t exp_q[$];
    int          exp_len[$];
    frame_word_t rx_q[$];
    logic        read_on;
    int          sent_cnt;
    int          err_cnt;
    int          chk_cnt;
    int          cycle_cnt = 0;
    int          skipped;
    int          got;

    tb_clock #(.PERIOD_NS(8.0)) clock_gen (.o_clk(clk));

    cim_top i_cim_top (
        .i_clk        (clk),
        .i_rst_n      (rst_n),
        .i_frame      (in_frame),
        .i_inport     (in_port),
        .o_fifo_word  (fifo_word),
        .o_fifo_empty (fifo_empty),
        .i_fifo_rd    (fifo_rd),
        .o_stat       (stat)
    );

    // 16 bit Fibonacci LFSR with taps 16 14 13 11
    function automatic logic [15:0] lfsr_step(input logic [15:0] s);
        return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
    endfunction

    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] r;
        r = '0;
        for (int i = 0; i < n; i++) begin
            lfsr_state = lfsr_step(lfsr_state);
            r = {r[30:0], lfsr_state[0]};
        end
        return r;
    endfunction

    task automatic check_value(input logic [WORD_W-1:0] got_v, input logic [WORD_W-1:0] exp_v,
                               input string what);
        chk_cnt++;
        if (got_v !== exp_v) begin
            err_cnt++;
            $display("ERROR at %0t ns: %s, got %h expected %h", $time, what, got_v, exp_v);
        end
    endtask

    //************************************************************************
    // stimulus and model
    //************************************************************************
    task automatic send_frame();
        int                n;
        logic              host;
        logic [PORT_W-1:0] port;
        frame_word_t       w;
        frame_word_t       hdr;
        n    = 2 + int'(rand_bits(3) % 7);
        host = (rand_bits(1) == 32'd1);
        port = PORT_W'(rand_bits(PORT_W));
        if (host) begin
            port = HOST_PORT;
        end else if (port == HOST_PORT) begin
            port = '0;
        end
        // header word with the tag in the top 16 payload bits and the port at the bottom
        hdr                      = '0;
        hdr.pos                  = POS_HEAD;
        hdr.data[DATA_W-1 -: 16] = ENCAP_TAG;
        hdr.data[PORT_W-1:0]     = port;
        if (host) begin
            exp_len.push_back(n - 1);
        end else begin
            exp_q.push_back(hdr);
            exp_len.push_back(n + 1);
        end
        for (int k = 0; k < n; k++) begin
            w.pos    = (k == 0) ? POS_HEAD : ((k == n - 1) ? POS_TAIL : POS_BODY);
            w.rsv    = 4'(rand_bits(4));
            w.data   = {rand_bits(32), rand_bits(32), rand_bits(32), rand_bits(32)};
            in_frame = '{wr: 1'b1, word: w};
            in_port  = port;
            if (host && k == 1) begin
                w.pos = POS_HEAD;
            end
            if (!host && k == 0) begin
                w.pos = POS_BODY;
            end
            if (!host || k > 0) begin
                exp_q.push_back(w);
            end
            @(posedge clk);
            #1;
        end
        in_frame.wr = 1'b0;
        sent_cnt++;
        repeat (2 + int'(rand_bits(1))) begin
            @(posedge clk);
            #1;
        end
    endtask

    // reader pops a word whenever enabled and the buffer holds data
    always @(posedge clk) begin
        #1;
        fifo_rd = 1'b0;
        if (read_on && !fifo_empty) begin
            rx_q.push_back(fifo_word);
            fifo_rd = 1'b1;
        end
    end

    // wait until every sent frame is read out or dropped and the buffer is empty
    task automatic wait_drained();
        do begin
            @(posedge clk);
            #2;
        end while (!(fifo_empty && !fifo_rd &&
                     (int'(stat.outpkt_cnt) + int'(stat.drop_cnt) == sent_cnt)));
    endtask

    task automatic check_frames(output int n_skip, output int n_got);
        frame_word_t head;
        int          n_rx;
        n_skip = 0;
        n_got  = 0;
        while (rx_q.size() > 0) begin
            head = rx_q[0];
            n_rx = 1;
            while (n_rx < rx_q.size() && rx_q[n_rx].pos != POS_HEAD) begin
                n_rx++;
            end
            // model frames with no match were dropped at the merger
            while (exp_len.size() > 0 && exp_q[0] !== head) begin
                repeat (exp_len[0]) void'(exp_q.pop_front());
                void'(exp_len.pop_front());
                n_skip++;
            end
            if (exp_len.size() == 0) begin
                err_cnt++;
                $display("ERROR at %0t ns: output frame with no matching model frame", $time);
                rx_q.delete();
            end else begin
                check_value(WORD_W'(n_rx), WORD_W'(exp_len[0]), "frame length");
                for (int i = 0; i < n_rx; i++) begin
                    if (i < exp_len[0]) begin
                        check_value(rx_q.pop_front(), exp_q.pop_front(), "frame word");
                    end else begin
                        void'(rx_q.pop_front());
                    end
                end
                if (exp_len[0] > n_rx) begin
                    repeat (exp_len[0] - n_rx) void'(exp_q.pop_front());
                end
                void'(exp_len.pop_front());
                n_got++;
            end
        end
        // trailing model frames never reached the buffer
        n_skip += exp_len.size();
        exp_q.delete();
        exp_len.delete();
    endtask

    always @(posedge clk) begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_cnt >= TIMEOUT_CYCLES) begin
            $display("timeout: the run did not finish within %0d cycles", TIMEOUT_CYCLES);
            $display("Simulation finished: FAIL");
            $finish;
        end
    end

    //************************************************************************
    // test sequence
    //************************************************************************
    initial begin
        in_frame = '0;
        in_port  = '0;
        fifo_rd  = 1'b0;
        read_on  = 1'b1;
        rst_n    = 1'b0;
        sent_cnt = 0;
        err_cnt  = 0;
        chk_cnt  = 0;
        repeat (10) @(posedge clk);
        #1;
        rst_n = 1'b1;
        check_value(WORD_W'(fifo_empty), WORD_W'(1), "buffer empty after reset");
        check_value(WORD_W'(stat), '0, "counters after reset");

        // mixed frames with the reader always on
        repeat (N_CONT) send_frame();
        wait_drained();
        check_frames(skipped, got);
        check_value(WORD_W'(skipped), '0, "frames missing under continuous read");
        check_value(WORD_W'(stat.inpkt_cnt), WORD_W'(N_CONT), "inpkt_cnt");
        check_value(WORD_W'(stat.outpkt_cnt), WORD_W'(N_CONT), "outpkt_cnt");
        check_value(WORD_W'(stat.drop_cnt), '0, "drop_cnt");

        // reader stalled so the buffer fills and whole frames get dropped
        read_on = 1'b0;
        repeat (N_BLOCK) send_frame();
        #1;
        read_on = 1'b1;
        wait_drained();
        check_frames(skipped, got);
        check_value(WORD_W'(got + int'(stat.drop_cnt)), WORD_W'(N_BLOCK), "received plus dropped");
        check_value(WORD_W'(stat.drop_cnt), WORD_W'(skipped), "drop_cnt vs skipped frames");
        check_value(WORD_W'(stat.drop_cnt != '0), WORD_W'(1), "drops under back-pressure");
        check_value(WORD_W'(stat.inpkt_cnt), WORD_W'(N_CONT + N_BLOCK), "inpkt_cnt total");
        check_value(WORD_W'(stat.outpkt_cnt), WORD_W'(N_CONT + got), "outpkt_cnt total");

        $display("checks: %0d, errors: %0d", chk_cnt, err_cnt);
        if (err_cnt == 0) begin
            $display("Simulation finished: PASS");
        end else begin
            $display("Simulation finished: FAIL");
        end
        $finish;
    end

endmodule

//--- src.f
common/cim_pkg.sv
logic/frame_dmux.sv
encap/frame_encap.sv
decap/frame_decap.sv
logic/frame_merge.sv
logic/sync_fifo.sv
logic/pkt_statistics.sv
logic/cim_top.sv
bench/tb_clock.sv
bench/cim_tb.sv

//--- Makefile
VERILATOR  = verilator
LINT_FLAGS = --lint-only -Wall --timing
SIM_FLAGS  = --binary --timing --assert -Wno-fatal
TOP        = cim_tb
FILELIST   = src.f
OBJ_DIR    = obj_dir
LOG        = sim.log
FAIL_MSG   = Simulation finished: FAIL
PASS_MSG   = Simulation finished: PASS

.PHONY: lint build sim clean

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

build:
	$(VERILATOR) $(SIM_FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

sim: build
	./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then echo "simulation failed"; exit 1; fi
	@grep -q "$(PASS_MSG)" $(LOG) || { echo "simulation ended without a result"; exit 1; }

clean:
	rm -rf $(OBJ_DIR) $(LOG)
